//--- common/rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  localparam logic [xlen-1:0] reset_pc = 32'h0000_3000;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    op_reg    = 7'b0110011,  // add sub
    op_imm    = 7'b0010011,  // addi slli
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_branch = 7'b1100011,  // beq bltu
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111
  } opcode_e;

  // control codes, same numbering as the old CTL register
  typedef enum logic [3:0] {
    alu_nop   = 4'h0,
    alu_add   = 4'h1,
    alu_sub   = 4'h2,
    alu_auipc = 4'h3,
    alu_lw    = 4'h4,
    alu_sw    = 4'h5,
    alu_beq   = 4'h6,
    alu_bltu  = 4'h7,
    alu_jal   = 4'h8,
    alu_slli  = 4'h9,
    alu_addi  = 4'ha
  } alu_op_e;

  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_word = 3'b010;
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bltu = 3'b110;

endpackage

`default_nettype wire

//--- core/instr_decode.sv
`timescale 1ns/1ns
`default_nettype none

module instr_decode import rv_pkg::*; (
  input  wire logic [xlen-1:0]       instr,
  output logic      [reg_addr_w-1:0] rs1,
  output logic      [reg_addr_w-1:0] rs2,
  output logic      [reg_addr_w-1:0] rd,
  output logic      [xlen-1:0]       imm,
  output alu_op_e                    alu_op,
  output logic                       rf_we,
  output logic                       dm_we
);

  opcode_e          opcode;
  logic [2:0]       funct3;
  logic [xlen-1:0]  imm_i;
  logic [xlen-1:0]  imm_s;
  logic [xlen-1:0]  imm_b;
  logic [xlen-1:0]  imm_u;
  logic [xlen-1:0]  imm_j;

  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];

  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];
  assign rd  = instr[11:7];

  // sign extended immediates, one per format
  assign imm_i = {{21{instr[31]}}, instr[30:20]};
  assign imm_s = {{21{instr[31]}}, instr[30:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'h000};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    alu_op = alu_nop;
    imm    = '0;
    rf_we  = 1'b0;
    dm_we  = 1'b0;
    case (opcode)
      op_reg: begin
        if (funct3 == f3_add) begin
          alu_op = instr[30] ? alu_sub : alu_add;
          rf_we  = 1'b1;
        end
      end
      op_imm: begin
        imm = imm_i;
        if (funct3 == f3_add) begin
          alu_op = alu_addi;
          rf_we  = 1'b1;
        end else if (funct3 == f3_sll) begin
          alu_op = alu_slli;  // shamt sits in imm[4:0]
          rf_we  = 1'b1;
        end
      end
      op_load: begin
        imm = imm_i;
        if (funct3 == f3_word) begin
          alu_op = alu_lw;
          rf_we  = 1'b1;
        end
      end
      op_store: begin
        imm = imm_s;
        if (funct3 == f3_word) begin
          alu_op = alu_sw;
          dm_we  = 1'b1;
        end
      end
      op_branch: begin
        imm = imm_b;
        if (funct3 == f3_beq) begin
          alu_op = alu_beq;
        end else if (funct3 == f3_bltu) begin
          alu_op = alu_bltu;
        end
      end
      op_auipc: begin
        imm    = imm_u;
        alu_op = alu_auipc;
        rf_we  = 1'b1;
      end
      op_jal: begin
        imm    = imm_j;
        alu_op = alu_jal;
        rf_we  = 1'b1;  // link in rd
      end
      default: begin
        alu_op = alu_nop;  // unknown opcode just steps pc
      end
    endcase
  end

endmodule

`default_nettype wire

//--- core/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage import rv_pkg::*; #(
  parameter int mem_addr_w = 8
) (
  input  wire logic                  clk_cpu,
  input  wire logic                  rstn,
  input  wire logic                  debug,
  input  wire alu_op_e               alu_op,
  input  wire logic [xlen-1:0]       imm,
  input  wire logic [xlen-1:0]       rs1_data,
  input  wire logic [xlen-1:0]       rs2_data,
  input  wire logic [xlen-1:0]       dm_rdata,
  output logic      [xlen-1:0]       wb_data,
  output logic      [mem_addr_w-1:0] dm_addr,
  output logic      [xlen-1:0]       dm_wdata,
  output logic      [xlen-1:0]       pc
);

  logic [xlen-1:0] op_b;
  logic [xlen-1:0] alu_sum;
  logic [xlen-1:0] pc_imm;
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] npc;
  logic            take;

  // register operand for add/sub, immediate for everything else
  assign op_b    = (alu_op == alu_add || alu_op == alu_sub) ? rs2_data : imm;
  assign alu_sum = (alu_op == alu_sub) ? rs1_data - op_b : rs1_data + op_b;

  assign pc_imm   = pc + imm;
  assign pc_plus4 = pc + 32'd4;

  // word index, byte offset dropped
  assign dm_addr  = alu_sum[mem_addr_w+1:2];
  assign dm_wdata = rs2_data;

  always_comb begin
    case (alu_op)
      alu_add,
      alu_sub,
      alu_addi:  wb_data = alu_sum;
      alu_slli:  wb_data = rs1_data << imm[4:0];
      alu_auipc: wb_data = pc_imm;
      alu_jal:   wb_data = pc_plus4;  // link
      alu_lw:    wb_data = dm_rdata;
      default:   wb_data = '0;
    endcase
  end

  always_comb begin
    case (alu_op)
      alu_jal:  take = 1'b1;
      alu_beq:  take = (rs1_data == rs2_data);
      alu_bltu: take = (rs1_data < rs2_data);  // unsigned
      default:  take = 1'b0;
    endcase
  end

  assign npc = take ? pc_imm : pc_plus4;

  always_ff @(posedge clk_cpu or negedge rstn) begin
    if (!rstn) begin
      pc <= reset_pc;
    end else if (!debug) begin
      pc <= npc;  // frozen during debug access
    end
  end

endmodule

`default_nettype wire

//--- core/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file import rv_pkg::*; (
  input  wire logic                  clk_cpu,
  input  wire logic                  rstn,
  input  wire logic [reg_addr_w-1:0] rs1,
  input  wire logic [reg_addr_w-1:0] rs2,
  output logic      [xlen-1:0]       rs1_data,
  output logic      [xlen-1:0]       rs2_data,
  input  wire logic                  we,
  input  wire logic [reg_addr_w-1:0] wa,
  input  wire logic [xlen-1:0]       wd,
  input  wire logic [reg_addr_w-1:0] dbg_ra,
  output logic      [xlen-1:0]       dbg_rd
);

  logic [xlen-1:0] regs [2**reg_addr_w];

  always_ff @(posedge clk_cpu or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < 2**reg_addr_w; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wa != '0) begin
      regs[wa] <= wd;  // x0 never written
    end
  end

  // x0 stays at its reset value of zero
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];
  assign dbg_rd   = regs[dbg_ra];

endmodule

`default_nettype wire

//--- source/word_mem.sv
`timescale 1ns/1ns
`default_nettype none

module word_mem import rv_pkg::*; #(
  parameter int mem_words  = 256,
  parameter int mem_addr_w = 8
) (
  input  wire logic                  clk_cpu,
  input  wire logic                  we,
  input  wire logic [mem_addr_w-1:0] wa,
  input  wire logic [xlen-1:0]       wd,
  input  wire logic [mem_addr_w-1:0] ra0,
  input  wire logic [mem_addr_w-1:0] ra1,
  output logic      [xlen-1:0]       rd0,
  output logic      [xlen-1:0]       rd1
);

  logic [xlen-1:0] mem [mem_words];

  always_ff @(posedge clk_cpu) begin
    if (we) begin
      mem[wa] <= wd;
    end
  end

  // async reads, like distributed ram
  assign rd0 = mem[ra0];
  assign rd1 = mem[ra1];

endmodule

`default_nettype wire

//--- source/rv_core_top.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core_top import rv_pkg::*; #(
  parameter int mem_words  = 256,
  parameter int mem_addr_w = 8
) (
  input  wire logic            clk_cpu,
  input  wire logic            rstn,
  input  wire logic            debug,
  input  wire logic [xlen-1:0] addr,
  input  wire logic [xlen-1:0] data_l,
  input  wire logic            we_im,
  input  wire logic            we_dm,
  output logic      [xlen-1:0] dout_rf,
  output logic      [xlen-1:0] dout_im,
  output logic      [xlen-1:0] dout_dm,
  output logic      [xlen-1:0] pc
);

  logic [xlen-1:0]       instr;
  logic [reg_addr_w-1:0] rs1;
  logic [reg_addr_w-1:0] rs2;
  logic [reg_addr_w-1:0] rd;
  logic [xlen-1:0]       imm;
  alu_op_e               alu_op;
  logic                  rf_we;
  logic                  dm_we;
  logic [xlen-1:0]       rs1_data;
  logic [xlen-1:0]       rs2_data;
  logic [xlen-1:0]       wb_data;
  logic [mem_addr_w-1:0] dm_addr;
  logic [xlen-1:0]       dm_wdata;
  logic [xlen-1:0]       dm_rdata;
  logic [xlen-1:0]       rf_dbg;
  logic [xlen-1:0]       im_dbg;
  logic [xlen-1:0]       dm_dbg;
  logic                  core_rf_we;
  logic                  core_dm_we;
  logic                  dm_we_mux;
  logic [mem_addr_w-1:0] dm_wa;
  logic [xlen-1:0]       dm_wd;

  // core writes only outside debug and reset
  assign core_rf_we = rf_we & ~debug;
  assign core_dm_we = dm_we & ~debug & rstn;

  assign dm_we_mux = debug ? we_dm : core_dm_we;
  assign dm_wa     = debug ? addr[mem_addr_w-1:0] : dm_addr;
  assign dm_wd     = debug ? data_l : dm_wdata;

  instr_decode dec0 (
    .instr, .rs1, .rs2, .rd, .imm, .alu_op, .rf_we, .dm_we
  );

  execute_stage #(.mem_addr_w(mem_addr_w)) ex0 (
    .clk_cpu, .rstn, .debug, .alu_op, .imm, .rs1_data, .rs2_data,
    .dm_rdata, .wb_data, .dm_addr, .dm_wdata, .pc
  );

  reg_file rf0 (
    .clk_cpu, .rstn, .rs1, .rs2, .rs1_data, .rs2_data,
    .we(core_rf_we), .wa(rd), .wd(wb_data),
    .dbg_ra(addr[reg_addr_w-1:0]), .dbg_rd(rf_dbg)
  );

  word_mem #(.mem_words(mem_words), .mem_addr_w(mem_addr_w)) im0 (
    .clk_cpu, .we(debug & we_im), .wa(addr[mem_addr_w-1:0]), .wd(data_l),
    .ra0(pc[mem_addr_w+1:2]), .ra1(addr[mem_addr_w-1:0]),
    .rd0(instr), .rd1(im_dbg)
  );

  word_mem #(.mem_words(mem_words), .mem_addr_w(mem_addr_w)) dm0 (
    .clk_cpu, .we(dm_we_mux), .wa(dm_wa), .wd(dm_wd),
    .ra0(dm_addr), .ra1(addr[mem_addr_w-1:0]),
    .rd0(dm_rdata), .rd1(dm_dbg)
  );

  // readback only visible in debug
  assign dout_rf = debug ? rf_dbg : '0;
  assign dout_im = debug ? im_dbg : '0;
  assign dout_dm = debug ? dm_dbg : '0;

endmodule

`default_nettype wire

//--- test/rv_core_props.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core_props (
  input wire logic        clk_cpu,
  input wire logic        rstn,
  input wire logic        debug,
  input wire logic [31:0] pc,
  input wire logic [31:0] instr,
  input wire logic        we_dm,
  input wire logic [31:0] rf_at_rd,
  input wire logic [31:0] dm_at_addr
);

  int assert_fails = 0;

  pc_hold_in_debug: assert property (
    @(posedge clk_cpu) disable iff (!rstn) debug |=> $stable(pc)
  ) else begin
    assert_fails++;
    $error("pc changed while debug was high");
  end

  // target register of the current instruction keeps its value
  rf_frozen_in_debug: assert property (
    @(posedge clk_cpu) disable iff (!rstn)
      debug |=> (!$stable(instr) || $stable(rf_at_rd))
  ) else begin
    assert_fails++;
    $error("register file changed while debug was high");
  end

  dm_frozen_in_debug: assert property (
    @(posedge clk_cpu) disable iff (!rstn)
      debug && !we_dm |=> (!$stable(instr) || $stable(dm_at_addr))
  ) else begin
    assert_fails++;
    $error("data memory changed while debug was high without a debug write");
  end

  pc_word_aligned: assert property (
    @(posedge clk_cpu) disable iff (!rstn) pc[1:0] == 2'b00
  ) else begin
    assert_fails++;
    $error("pc is not word aligned");
  end

endmodule

bind rv_core_top rv_core_props props0 (
  .clk_cpu(clk_cpu), .rstn(rstn), .debug(debug), .pc(pc), .instr(instr),
  .we_dm(we_dm), .rf_at_rd(rf0.regs[rd]), .dm_at_addr(dm0.mem[dm_addr])
);

`default_nettype wire

//--- test/rv_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core_tb;

  localparam logic [31:0] start_pc    = 32'h0000_3000;
  localparam int          n_prog      = 21;
  localparam int          n_regs      = 15;
  localparam int          run_cycles  = 40;
  localparam int          dm_word     = 3;
  localparam logic [31:0] final_pc    = start_pc + 32'(4 * (n_prog - 1));
  localparam int          test_cycles = 5 + (n_prog + 1) + 2 + (n_prog + 1) + run_cycles
                                        + 2 + n_regs + 2;
  localparam int          cycle_limit = 4 * test_cycles;

  localparam logic [6:0] opc_imm  = 7'b0010011;
  localparam logic [6:0] opc_load = 7'b0000011;

  logic        clk_cpu;
  logic        rstn;
  logic        debug;
  logic [31:0] addr;
  logic [31:0] data_l;
  logic        we_im;
  logic        we_dm;
  logic [31:0] dout_rf;
  logic [31:0] dout_im;
  logic [31:0] dout_dm;
  logic [31:0] pc;

  int          errors;
  int          checks;
  int          cycles = 0;
  logic [31:0] prog [n_prog];
  int          reg_idx [n_regs];
  logic [31:0] reg_exp [n_regs];

  rv_core_top #(.mem_words(256), .mem_addr_w(8)) dut0 (
    .clk_cpu, .rstn, .debug, .addr, .data_l, .we_im, .we_dm,
    .dout_rf, .dout_im, .dout_dm, .pc
  );

  initial begin
    clk_cpu = 1'b0;
    forever #10 clk_cpu = ~clk_cpu;
  end

  always @(posedge clk_cpu) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, the run did not finish", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  // RV32I encodings, fields taken straight from the ISA layout
  function automatic logic [31:0] r_type_word(input int f7, input int rs2, input int rs1,
                                              input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type_word(input int imm, input int rs1, input int f3,
                                              input int rd, input logic [6:0] opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic logic [31:0] s_type_word(input int imm, input int rs2, input int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type_word(input int imm, input int rs2, input int rs1,
                                              input int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] u_type_word(input int imm20, input int rd);
    return {imm20[19:0], rd[4:0], 7'b0010111};
  endfunction

  function automatic logic [31:0] j_type_word(input int imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
  endfunction

  task automatic expect_reg(input int k, input int idx, input logic [31:0] val);
    reg_idx[k] = idx;
    reg_exp[k] = val;
  endtask

  task automatic build_tables();
    prog[0]  = i_type_word(5, 0, 0, 1, opc_imm);       // addi x1, x0, 5
    prog[1]  = i_type_word(-3, 0, 0, 2, opc_imm);      // addi x2, x0, -3
    prog[2]  = r_type_word(0, 2, 1, 0, 3);             // add x3, x1, x2
    prog[3]  = r_type_word(32, 2, 1, 0, 4);            // sub x4, x1, x2
    prog[4]  = i_type_word(4, 1, 1, 5, opc_imm);       // slli x5, x1, 4
    prog[5]  = i_type_word(7, 1, 0, 0, opc_imm);       // addi x0, x1, 7
    prog[6]  = s_type_word(12, 4, 0);                  // sw x4, 12(x0)
    prog[7]  = i_type_word(12, 0, 2, 6, opc_load);     // lw x6, 12(x0)
    prog[8]  = u_type_word(32'h12345, 7);              // auipc x7
    prog[9]  = j_type_word(8, 8);                      // jal x8, +8
    prog[10] = i_type_word(1, 0, 0, 9, opc_imm);       // skipped
    prog[11] = b_type_word(8, 1, 1, 0);                // beq x1, x1 taken
    prog[12] = i_type_word(1, 0, 0, 10, opc_imm);      // skipped
    prog[13] = b_type_word(8, 2, 1, 6);                // bltu x1, x2 taken
    prog[14] = i_type_word(1, 0, 0, 11, opc_imm);      // skipped
    prog[15] = b_type_word(8, 2, 1, 0);                // beq x1, x2 not taken
    prog[16] = i_type_word(9, 0, 0, 12, opc_imm);
    prog[17] = b_type_word(8, 1, 2, 6);                // bltu x2, x1 not taken
    prog[18] = i_type_word(4, 0, 0, 13, opc_imm);
    prog[19] = 32'hffff_ffff;                          // unknown opcode, rd x31
    prog[20] = j_type_word(0, 0);                      // jal x0, 0

    expect_reg(0, 0, 32'h0);
    expect_reg(1, 1, 32'd5);
    expect_reg(2, 2, 32'hffff_fffd);
    expect_reg(3, 3, 32'd2);
    expect_reg(4, 4, 32'd8);
    expect_reg(5, 5, 32'h50);
    expect_reg(6, 6, 32'd8);
    expect_reg(7, 7, start_pc + 32'h1234_5000 + 32'h20);
    expect_reg(8, 8, start_pc + 32'h28);
    expect_reg(9, 9, 32'h0);
    expect_reg(10, 10, 32'h0);
    expect_reg(11, 11, 32'h0);
    expect_reg(12, 12, 32'd9);
    expect_reg(13, 13, 32'd4);
    expect_reg(14, 31, 32'h0);
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
    checks++;
    assert (got === expected) else begin
      errors++;
      $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, expected);
    end
  endtask

  initial begin
    rstn   = 1'b0;
    debug  = 1'b0;
    addr   = 32'h0;
    data_l = 32'h0;
    we_im  = 1'b0;
    we_dm  = 1'b0;
    errors = 0;
    checks = 0;
    build_tables();

    repeat (3) @(posedge clk_cpu);
    @(negedge clk_cpu);
    check_word("pc", pc, start_pc);
    check_word("dout_rf", dout_rf, 32'h0);
    check_word("dout_im", dout_im, 32'h0);
    check_word("dout_dm", dout_dm, 32'h0);
    @(posedge clk_cpu);
    rstn  <= 1'b1;
    debug <= 1'b1;  // enter debug before the core can fetch

    for (int i = 0; i < n_prog; i++) begin
      @(posedge clk_cpu);
      addr   <= i;
      data_l <= prog[i];
      we_im  <= 1'b1;
    end
    @(posedge clk_cpu);
    we_im  <= 1'b0;
    addr   <= dm_word;
    data_l <= 32'ha5a5_0003;  // overwritten later by sw
    we_dm  <= 1'b1;
    @(posedge clk_cpu);
    we_dm <= 1'b0;

    for (int i = 0; i < n_prog; i++) begin
      @(posedge clk_cpu);
      addr <= i;
      @(negedge clk_cpu);
      check_word($sformatf("dout_im[%0d]", i), dout_im, prog[i]);
    end
    check_word("pc", pc, start_pc);

    @(posedge clk_cpu);
    debug <= 1'b0;
    addr  <= dm_word;  // nonzero in all three stores after the run
    repeat (run_cycles) @(posedge clk_cpu);
    @(negedge clk_cpu);
    check_word("dout_rf", dout_rf, 32'h0);
    check_word("dout_im", dout_im, 32'h0);
    check_word("dout_dm", dout_dm, 32'h0);
    @(posedge clk_cpu);
    debug <= 1'b1;
    @(negedge clk_cpu);
    check_word("pc", pc, final_pc);

    for (int k = 0; k < n_regs; k++) begin
      @(posedge clk_cpu);
      addr <= reg_idx[k];
      @(negedge clk_cpu);
      check_word($sformatf("dout_rf[x%0d]", reg_idx[k]), dout_rf, reg_exp[k]);
    end
    @(posedge clk_cpu);
    addr <= dm_word;
    @(negedge clk_cpu);
    check_word($sformatf("dout_dm[%0d]", dm_word), dout_dm, 32'd8);

    $display("checks: %0d, value errors: %0d, assertion failures: %0d",
             checks, errors, dut0.props0.assert_fails);
    errors += dut0.props0.assert_fails;
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
common/rv_pkg.sv
core/instr_decode.sv
core/execute_stage.sv
core/reg_file.sv
source/word_mem.sv
source/rv_core_top.sv
test/rv_core_props.sv
test/rv_core_tb.sv

//--- Makefile
TOP := rv_core_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Testbench passed$$"

clean:
	rm -rf obj_dir
